//--- verilog.f
rtl/pet_mem_pkg.sv
rtl/axil_req_frontend.sv
rtl/sram_byte_sequencer.sv
rtl/axil_resp_backend.sv
rtl/pet_mem_bridge.sv
verif/sram_model.sv
verif/pet_mem_scoreboard.sv
verif/pet_mem_bridge_chk.sv
verif/pet_mem_bridge_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = pet_mem_bridge_tb
FILELIST  = verilog.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- verif/pet_mem_tests.txt
# kind address wdata wstrb expected_rdata expected_resp, all hex; resp 0 is OKAY, 2 is SLVERR
# Reads carry zero wdata and wstrb; writes expect zero read data
R 00000000 00000000 0 00000000 0
W 00000100 11223344 f 00000000 0
R 00000100 00000000 0 11223344 0
W 0001fffc deadbeef f 00000000 0
R 0001fffc 00000000 0 deadbeef 0
W 00000100 aabbccdd 5 00000000 0
R 00000100 00000000 0 11bb33dd 0
W 00000104 cafef00d f 00000000 0
W 00000104 12345678 a 00000000 0
R 00000104 00000000 0 12fe560d 0
W 00020100 55555555 f 00000000 2
R 00020100 00000000 0 00000000 2
R 00000100 00000000 0 11bb33dd 0
R 0003fffc 00000000 0 00000000 2
R 0001fffc 00000000 0 deadbeef 0
W 00000200 01020304 f 00000000 0
W 00000204 05060708 f 00000000 0
R 00000200 00000000 0 01020304 0
W 00000208 090a0b0c 3 00000000 0
R 00000204 00000000 0 05060708 0
R 00000208 00000000 0 00000b0c 0
W 0001fff8 89abcdef f 00000000 0
R 0001fff8 00000000 0 89abcdef 0

//--- verif/pet_mem_bridge_tb.sv
/* Runs the operations of verif/pet_mem_tests.txt and must start in the project root.
   B and R ready stalls of 0 to 5 cycles come from a fixed seed. */
`timescale 1ns/1ps
`default_nettype none

module pet_mem_bridge_tb
    import pet_mem_pkg::*;
();

    localparam int    RESET_CYCLES = 8;
    localparam int    TIMEOUT      = 200;               // Cycles allowed per wait
    localparam int    SEED         = 57853;
    localparam string TESTS_FILE   = "verif/pet_mem_tests.txt";

    logic      clock_i;
    logic      rst_n_i;
    axil_req_t host;                                    // All host fields but the readies
    axil_req_t req;
    axil_rsp_t rsp;
    logic      bready;
    logic      rready;
    ram_addr_t ram_addr;
    ram_byte_t ram_wdata;
    ram_byte_t ram_rdata;
    logic      ram_we_n;
    logic      ram_oe_n;
    logic      aw_fire = 1'b0;
    logic      ar_fire = 1'b0;
    logic      b_fire  = 1'b0;
    logic      r_fire  = 1'b0;
    logic      exp_valid;
    logic      exp_is_write;
    int        exp_test;
    axi_addr_t exp_addr;
    axi_word_t exp_data;
    axi_resp_t exp_resp;
    int        pass_count;
    int        fail_count;
    int        pending;
    int        reset_errors = 0;
    int        stall_tab [64];
    string     fault = "";

    pet_mem_bridge dut0 (
        .clock_i    (clock_i),
        .rst_n_i    (rst_n_i),
        .axil_req_i (req),
        .axil_rsp_o (rsp),
        .ram_addr_o (ram_addr),
        .ram_data_o (ram_wdata),
        .ram_data_i (ram_rdata),
        .ram_we_n_o (ram_we_n),
        .ram_oe_n_o (ram_oe_n)
    );

    sram_model ram0 (
        .clock_i    (clock_i),
        .ram_addr_i (ram_addr),
        .ram_data_i (ram_wdata),
        .ram_data_o (ram_rdata),
        .ram_we_n_i (ram_we_n),
        .ram_oe_n_i (ram_oe_n)
    );

    pet_mem_scoreboard sb0 (
        .clock_i        (clock_i),
        .rst_n_i        (rst_n_i),
        .axil_req_i     (req),
        .axil_rsp_i     (rsp),
        .exp_valid_i    (exp_valid),
        .exp_is_write_i (exp_is_write),
        .exp_test_i     (exp_test),
        .exp_addr_i     (exp_addr),
        .exp_data_i     (exp_data),
        .exp_resp_i     (exp_resp),
        .pass_count_o   (pass_count),
        .fail_count_o   (fail_count),
        .pending_o      (pending)
    );

    always_comb begin
        req        = host;
        req.bready = bready;
        req.rready = rready;
    end

    // Handshakes seen at the last rising edge
    always @(posedge clock_i) begin
        aw_fire <= req.awvalid & rsp.awready & req.wvalid & rsp.wready;
        ar_fire <= req.arvalid & rsp.arready;
        b_fire  <= rsp.bvalid & req.bready;
        r_fire  <= rsp.rvalid & req.rready;
    end

    initial begin
        clock_i = 1'b0;
        forever #2 clock_i = ~clock_i;
    end

    // ------------------------------------------------------------
    // B and R back-pressure with a new stall after each response
    initial begin : ready_stalls
        int b_stall;
        int r_stall;
        int pick;
        b_stall = 0;
        r_stall = 0;
        pick    = 0;
        bready  = 1'b0;
        rready  = 1'b0;
        forever begin
            @(negedge clock_i);
            if (b_fire) begin
                b_stall = stall_tab[pick % 64];
                pick++;
            end
            if (r_fire) begin
                r_stall = stall_tab[pick % 64];
                pick++;
            end
            bready = (b_stall == 0);
            rready = (r_stall == 0);
            if (b_stall > 0 && rsp.bvalid) begin
                b_stall--;                              // Count only cycles with a response
            end
            if (r_stall > 0 && rsp.rvalid) begin
                r_stall--;
            end
        end
    end

    // ------------------------------------------------------------
    // One AW/W or AR request that starts and ends on a falling edge
    task automatic issue_op(input bit is_write, input int test_no, input axi_addr_t addr,
                            input axi_word_t data, input axi_strb_t strb,
                            input axi_word_t rdata_exp, input axi_resp_t resp_exp);
        int waited;
        waited = 0;
        if (is_write) begin
            host.awvalid = 1'b1;
            host.awaddr  = addr;
            host.wvalid  = 1'b1;
            host.wdata   = data;
            host.wstrb   = strb;
        end else begin
            host.arvalid = 1'b1;
            host.araddr  = addr;
        end
        exp_valid    = 1'b1;
        exp_is_write = is_write;
        exp_test     = test_no;
        exp_addr     = addr;
        exp_data     = rdata_exp;
        exp_resp     = resp_exp;
        do begin
            @(negedge clock_i);
            exp_valid = 1'b0;
            waited++;
        end while (!(is_write ? aw_fire : ar_fire) && waited < TIMEOUT);
        host.awvalid = 1'b0;
        host.wvalid  = 1'b0;
        host.arvalid = 1'b0;
        if (!(is_write ? aw_fire : ar_fire)) begin
            fault = $sformatf("timed out waiting for %s on test %0d",
                              is_write ? "awready and wready" : "arready", test_no);
            $display("%s", fault);
        end
    endtask

    // ------------------------------------------------------------
    initial begin : main
        int        fd;
        int        test_no;
        int        fields;
        int        waited;
        string     line;
        byte       kind;
        axi_addr_t addr;
        axi_word_t data;
        axi_strb_t strb;
        axi_word_t rdata_exp;
        axi_resp_t resp_exp;

        void'($urandom(SEED));
        foreach (stall_tab[i]) begin
            stall_tab[i] = int'($urandom % 6);
        end
        host         = '0;
        host.awvalid = 1'b1;                            // Requests held in reset stay untaken
        host.wvalid  = 1'b1;
        host.arvalid = 1'b1;
        exp_valid    = 1'b0;
        exp_is_write = 1'b0;
        exp_test     = 0;
        exp_addr     = '0;
        exp_data     = '0;
        exp_resp     = '0;
        rst_n_i      = 1'b0;
        repeat (RESET_CYCLES) begin
            @(negedge clock_i);
            if ({rsp.awready, rsp.wready, rsp.arready, rsp.bvalid, rsp.rvalid} !== 5'b0) begin
                $display("ERR {awready,wready,arready,bvalid,rvalid} expected 00 got %h",
                         {rsp.awready, rsp.wready, rsp.arready, rsp.bvalid, rsp.rvalid});
                reset_errors++;
            end
        end
        host    = '0;
        rst_n_i = 1'b1;

        test_no = 0;
        fd      = $fopen(TESTS_FILE, "r");
        if (fd == 0) begin
            fault = {"cannot open ", TESTS_FILE};
            $display("%s", fault);
        end
        while (fd != 0 && fault == "" && $fgets(line, fd) > 0) begin
            kind = line.getc(0);
            if (line.len() < 2 || kind == "#") begin
                continue;                               // Blank or comment line
            end
            fields = $sscanf(line.substr(2, line.len() - 1), "%h %h %h %h %h",
                             addr, data, strb, rdata_exp, resp_exp);
            if (fields != 5 || !(kind == "W" || kind == "R")) begin
                fault = {"malformed line in tests file: ", line};
                $display("%s", fault);
            end else begin
                test_no++;
                issue_op(kind == "W", test_no, addr, data, strb, rdata_exp, resp_exp);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        waited = 0;
        while (fault == "" && pending != 0 && waited < TIMEOUT) begin
            @(negedge clock_i);
            waited++;
        end
        if (fault == "" && pending != 0) begin
            fault = "timed out waiting for the outstanding B and R responses";
            $display("%s", fault);
        end
        $display("tests %0d, passed %0d, failed %0d, reset errors %0d",
                 test_no, pass_count, fail_count, reset_errors);
        if (fault == "" && fail_count == 0 && reset_errors == 0 && pass_count == test_no) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/pet_mem_bridge_chk.sv
/* Bound into pet_mem_bridge; watches the B and R handshakes and the SRAM enables.
   Handshake and enable checks are off in reset; a separate check covers the enables there. */
`timescale 1ns/1ps
`default_nettype none

module pet_mem_bridge_chk
    import pet_mem_pkg::*;
(
    input logic      clock_i,
    input logic      rst_n_i,
    input axil_req_t axil_req_i,
    input axil_rsp_t axil_rsp_i,
    input logic      ram_we_n_i,
    input logic      ram_oe_n_i
);

    // ------------------------------------------------------------
    // Response channels hold until the host takes them
    b_hold: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        axil_rsp_i.bvalid && !axil_req_i.bready
        |=> axil_rsp_i.bvalid && $stable(axil_rsp_i.bresp))
        else $error("bvalid or bresp changed before bready");

    r_hold: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        axil_rsp_i.rvalid && !axil_req_i.rready
        |=> axil_rsp_i.rvalid && $stable(axil_rsp_i.rdata) && $stable(axil_rsp_i.rresp))
        else $error("rvalid, rdata or rresp changed before rready");

    // ------------------------------------------------------------
    // SRAM enables
    one_enable: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        ram_we_n_i || ram_oe_n_i)
        else $error("SRAM write and output enables low together");

    idle_in_reset: assert property (@(posedge clock_i)
        !rst_n_i && $past(!rst_n_i) |-> ram_we_n_i && ram_oe_n_i)
        else $error("SRAM enable low during reset");

endmodule

bind pet_mem_bridge pet_mem_bridge_chk chk0 (
    .clock_i    (clock_i),
    .rst_n_i    (rst_n_i),
    .axil_req_i (axil_req_i),
    .axil_rsp_i (axil_rsp_o),
    .ram_we_n_i (ram_we_n_o),
    .ram_oe_n_i (ram_oe_n_o)
);

`default_nettype wire

//--- verif/pet_mem_scoreboard.sv
/* Matches B and R responses against expectations in issue order, one queue per channel.
   An expectation must be posted before its response can arrive. */
`timescale 1ns/1ps
`default_nettype none

module pet_mem_scoreboard
    import pet_mem_pkg::*;
(
    input  logic      clock_i,
    input  logic      rst_n_i,
    input  axil_req_t axil_req_i,
    input  axil_rsp_t axil_rsp_i,
    input  logic      exp_valid_i,
    input  logic      exp_is_write_i,
    input  int        exp_test_i,
    input  axi_addr_t exp_addr_i,
    input  axi_word_t exp_data_i,
    input  axi_resp_t exp_resp_i,
    output int        pass_count_o,
    output int        fail_count_o,
    output int        pending_o
);

    typedef struct packed {
        int        test;
        axi_addr_t addr;
        axi_word_t data;                                // Read data, zero for writes
        axi_resp_t resp;
    } expect_t;

    expect_t b_q[$];
    expect_t r_q[$];

    task automatic finish_test(input expect_t e, input string kind, input bit ok);
        $display("test %0d %s %08h %s", e.test, kind, e.addr, ok ? "ok" : "mismatch");
        if (ok) begin
            pass_count_o++;
        end else begin
            fail_count_o++;
        end
    endtask

    // ------------------------------------------------------------
    always @(posedge clock_i) begin : compare
        expect_t e;
        bit      ok;
        if (!rst_n_i) begin
            b_q.delete();
            r_q.delete();
            pass_count_o = 0;
            fail_count_o = 0;
        end else begin
            if (exp_valid_i) begin
                e = '{exp_test_i, exp_addr_i, exp_data_i, exp_resp_i};
                if (exp_is_write_i) begin
                    b_q.push_back(e);
                end else begin
                    r_q.push_back(e);
                end
            end
            if (axil_rsp_i.bvalid && axil_req_i.bready) begin
                if (b_q.size() == 0) begin
                    $display("B response arrived with no write outstanding");
                    fail_count_o++;
                end else begin
                    e  = b_q.pop_front();
                    ok = (axil_rsp_i.bresp === e.resp);
                    if (!ok) begin
                        $display("ERR test %0d bresp expected %h got %h",
                                 e.test, e.resp, axil_rsp_i.bresp);
                    end
                    finish_test(e, "W", ok);
                end
            end
            if (axil_rsp_i.rvalid && axil_req_i.rready) begin
                if (r_q.size() == 0) begin
                    $display("R response arrived with no read outstanding");
                    fail_count_o++;
                end else begin
                    e  = r_q.pop_front();
                    ok = 1'b1;
                    if (axil_rsp_i.rdata !== e.data) begin
                        $display("ERR test %0d rdata expected %08h got %08h",
                                 e.test, e.data, axil_rsp_i.rdata);
                        ok = 1'b0;
                    end
                    if (axil_rsp_i.rresp !== e.resp) begin
                        $display("ERR test %0d rresp expected %h got %h",
                                 e.test, e.resp, axil_rsp_i.rresp);
                        ok = 1'b0;
                    end
                    finish_test(e, "R", ok);
                end
            end
        end
        pending_o = b_q.size() + r_q.size();
    end

endmodule

`default_nettype wire

//--- verif/sram_model.sv
/* Byte-wide synchronous SRAM of 128 KiB that starts as all zeros.
   Read data is registered on the clock edge; a write wins when both enables are low. */
`timescale 1ns/1ps
`default_nettype none

module sram_model
    import pet_mem_pkg::*;
(
    input  logic      clock_i,
    input  ram_addr_t ram_addr_i,
    input  ram_byte_t ram_data_i,
    output ram_byte_t ram_data_o,
    input  logic      ram_we_n_i,
    input  logic      ram_oe_n_i
);

    ram_byte_t mem [2**RAM_ADDR_WIDTH];

    initial begin
        mem        = '{default: '0};
        ram_data_o = '0;
    end

    always @(posedge clock_i) begin
        if (!ram_we_n_i) begin
            mem[ram_addr_i] <= ram_data_i;
        end else if (!ram_oe_n_i) begin
            ram_data_o <= mem[ram_addr_i];              // Seen by the DUT one cycle later
        end
    end

endmodule

`default_nettype wire

//--- rtl/pet_mem_bridge.sv
/* AXI4-Lite slave onto an 8-bit SRAM; one word is four byte cycles.
   No bursts, no unaligned access; AWPROT and ARPROT are not carried. */
`timescale 1ns/1ps
`default_nettype none

module pet_mem_bridge
    import pet_mem_pkg::*;
(
    input  logic      clock_i,
    input  logic      rst_n_i,
    input  axil_req_t axil_req_i,
    output axil_rsp_t axil_rsp_o,
    output ram_addr_t ram_addr_o,
    output ram_byte_t ram_data_o,
    input  ram_byte_t ram_data_i,
    output logic      ram_we_n_o,
    output logic      ram_oe_n_o
);

    logic [2:0] ready_bits;                             // {awready, wready, arready}
    mem_cmd_t   cmd;
    logic       cmd_ready;
    mem_rsp_t   rsp;
    logic       rsp_ready;
    axil_rsp_t  b_r;

    // ------------------------------------------------------------
    // Request side
    axil_req_frontend u_frontend (
        .clock_i      (clock_i),
        .rst_n_i      (rst_n_i),
        .axil_req_i   (axil_req_i),
        .axil_ready_o (ready_bits),
        .cmd_o        (cmd),
        .cmd_ready_i  (cmd_ready)
    );

    // ------------------------------------------------------------
    // SRAM byte cycles
    sram_byte_sequencer u_sequencer (
        .clock_i     (clock_i),
        .rst_n_i     (rst_n_i),
        .cmd_i       (cmd),
        .cmd_ready_o (cmd_ready),
        .rsp_o       (rsp),
        .rsp_ready_i (rsp_ready),
        .ram_addr_o  (ram_addr_o),
        .ram_data_o  (ram_data_o),
        .ram_data_i  (ram_data_i),
        .ram_we_n_o  (ram_we_n_o),
        .ram_oe_n_o  (ram_oe_n_o)
    );

    // ------------------------------------------------------------
    // Response side
    axil_resp_backend u_backend (
        .clock_i     (clock_i),
        .rst_n_i     (rst_n_i),
        .rsp_i       (rsp),
        .rsp_ready_o (rsp_ready),
        .axil_b_r_o  (b_r),
        .axil_req_i  (axil_req_i)
    );

    always_comb begin
        axil_rsp_o         = b_r;
        axil_rsp_o.awready = ready_bits[2];
        axil_rsp_o.wready  = ready_bits[1];
        axil_rsp_o.arready = ready_bits[0];
    end

endmodule

`default_nettype wire

//--- rtl/axil_resp_backend.sv
/* Separate B and R registers; each takes a new result only when empty.
   The ready fields of the output struct are left at zero for the top to fill. */
`timescale 1ns/1ps
`default_nettype none

module axil_resp_backend
    import pet_mem_pkg::*;
(
    input  logic      clock_i,
    input  logic      rst_n_i,
    input  mem_rsp_t  rsp_i,
    output logic      rsp_ready_o,
    output axil_rsp_t axil_b_r_o,
    input  axil_req_t axil_req_i                        // Only bready and rready
);

    logic      b_valid_q;
    axi_resp_t bresp_q;
    logic      r_valid_q;
    axi_word_t rdata_q;
    axi_resp_t rresp_q;
    logic      load;

    assign rsp_ready_o = rsp_i.is_write ? ~b_valid_q : ~r_valid_q;  // Matching channel empty
    assign load        = rsp_i.valid & rsp_ready_o;

    // ------------------------------------------------------------
    // B channel
    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            b_valid_q <= 1'b0;
        end else if (b_valid_q && axil_req_i.bready) begin
            b_valid_q <= 1'b0;
        end else if (load && rsp_i.is_write) begin
            b_valid_q <= 1'b1;
            bresp_q   <= rsp_i.resp;
        end
    end

    // ------------------------------------------------------------
    // R channel
    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            r_valid_q <= 1'b0;
        end else if (r_valid_q && axil_req_i.rready) begin
            r_valid_q <= 1'b0;
        end else if (load && !rsp_i.is_write) begin
            r_valid_q <= 1'b1;
            rdata_q   <= rsp_i.rdata;
            rresp_q   <= rsp_i.resp;
        end
    end

    always_comb begin
        axil_b_r_o        = '0;
        axil_b_r_o.bvalid = b_valid_q;
        axil_b_r_o.bresp  = bresp_q;
        axil_b_r_o.rvalid = r_valid_q;
        axil_b_r_o.rdata  = rdata_q;
        axil_b_r_o.rresp  = rresp_q;
    end

endmodule

`default_nettype wire

//--- rtl/sram_byte_sequencer.sv
/* Runs one word as four SRAM byte cycles, lane 0 first (little endian).
   Expects an SRAM with registered read data, valid one cycle after the address. */
`timescale 1ns/1ps
`default_nettype none

module sram_byte_sequencer
    import pet_mem_pkg::*;
(
    input  logic      clock_i,
    input  logic      rst_n_i,
    input  mem_cmd_t  cmd_i,
    output logic      cmd_ready_o,
    output mem_rsp_t  rsp_o,
    input  logic      rsp_ready_i,
    output ram_addr_t ram_addr_o,
    output ram_byte_t ram_data_o,
    input  ram_byte_t ram_data_i,
    output logic      ram_we_n_o,
    output logic      ram_oe_n_o
);

    seq_state_t                   state_q;
    logic [$clog2(LANES)-1:0]     lane_q;               // Byte lane in flight
    logic [$clog2(LANES)-1:0]     prev_lane;            // Lane whose byte is on ram_data_i
    logic                         last_lane;

    logic      is_write_q;
    ram_addr_t base_q;
    axi_word_t wdata_q;
    axi_strb_t wstrb_q;
    axi_word_t rdata_q;                                 // Assembled read word
    axi_resp_t resp_q;

    assign prev_lane = lane_q - 1'b1;
    assign last_lane = (lane_q == ($clog2(LANES))'(LANES - 1));

    // ------------------------------------------------------------
    // SRAM pins
    assign ram_addr_o = base_q | ram_addr_t'(lane_q);
    assign ram_data_o = wdata_q[lane_q*DATA_WIDTH +: DATA_WIDTH];
    assign ram_we_n_o = ~((state_q == WRITE_LANES) & wstrb_q[lane_q]);  // Skip unstrobed lanes
    assign ram_oe_n_o = ~(state_q == READ_LANES);

    // ------------------------------------------------------------
    // Handshakes
    assign cmd_ready_o = (state_q == IDLE);

    always_comb begin
        rsp_o.valid    = (state_q == DONE);
        rsp_o.is_write = is_write_q;
        rsp_o.rdata    = rdata_q;
        rsp_o.resp     = resp_q;
    end

    // ------------------------------------------------------------
    // FSM
    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            lane_q  <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    lane_q <= '0;
                    if (cmd_i.valid) begin
                        is_write_q <= cmd_i.is_write;
                        base_q     <= cmd_i.base;
                        wdata_q    <= cmd_i.wdata;
                        wstrb_q    <= cmd_i.wstrb;
                        rdata_q    <= '0;               // Error reads return zero
                        resp_q     <= cmd_i.err ? RESP_SLVERR : RESP_OKAY;
                        if (cmd_i.err) begin
                            state_q <= DONE;            // No SRAM cycle
                        end else if (cmd_i.is_write) begin
                            state_q <= WRITE_LANES;
                        end else begin
                            state_q <= READ_LANES;
                        end
                    end
                end
                WRITE_LANES: begin
                    lane_q <= lane_q + 1'b1;
                    if (last_lane) begin
                        state_q <= DONE;
                    end
                end
                READ_LANES: begin
                    // Byte of the previous lane arrives one cycle late
                    if (lane_q != '0) begin
                        rdata_q[prev_lane*DATA_WIDTH +: DATA_WIDTH] <= ram_data_i;
                    end
                    lane_q <= lane_q + 1'b1;
                    if (last_lane) begin
                        state_q <= READ_DRAIN;
                    end
                end
                READ_DRAIN: begin
                    rdata_q[(LANES-1)*DATA_WIDTH +: DATA_WIDTH] <= ram_data_i;  // Last lane
                    state_q <= DONE;
                end
                DONE: begin
                    if (rsp_ready_i) begin
                        state_q <= IDLE;                // Held here by back-pressure
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/axil_req_frontend.sv
/* AW and W are only taken together; AR waits while any write is pending or waiting.
   One request is held at a time; addresses at or above 128 KiB are flagged as errors. */
`timescale 1ns/1ps
`default_nettype none

module axil_req_frontend
    import pet_mem_pkg::*;
(
    input  logic       clock_i,
    input  logic       rst_n_i,
    input  axil_req_t  axil_req_i,
    output logic [2:0] axil_ready_o,                    // {awready, wready, arready}
    output mem_cmd_t   cmd_o,
    input  logic       cmd_ready_i
);

    logic     live_q;                                   // Low until the first edge out of reset
    mem_cmd_t hold_q;                                   // Holding register
    logic     wr_waiting;
    logic     wr_take;
    logic     rd_take;

    // ------------------------------------------------------------
    // Address helpers
    function automatic logic out_of_range(input axi_addr_t addr);
        return |addr[AXI_ADDR_WIDTH-1:RAM_ADDR_WIDTH];
    endfunction

    function automatic ram_addr_t word_base(input axi_addr_t addr);
        return {addr[RAM_ADDR_WIDTH-1:$clog2(LANES)], {$clog2(LANES){1'b0}}};
    endfunction

    // ------------------------------------------------------------
    // Acceptance
    assign wr_waiting = axil_req_i.awvalid | axil_req_i.wvalid;

    assign wr_take = live_q & ~hold_q.valid
                   & axil_req_i.awvalid & axil_req_i.wvalid;   // Both halves in one beat

    assign rd_take = live_q & ~hold_q.valid & ~wr_waiting
                   & axil_req_i.arvalid;                       // Writes go first

    assign axil_ready_o = {wr_take, wr_take, rd_take};

    assign cmd_o = hold_q;

    // ------------------------------------------------------------
    // Holding register
    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            live_q       <= 1'b0;
            hold_q.valid <= 1'b0;
        end else begin
            live_q <= 1'b1;
            if (wr_take) begin
                hold_q.valid    <= 1'b1;
                hold_q.is_write <= 1'b1;
                hold_q.base     <= word_base(axil_req_i.awaddr);
                hold_q.wdata    <= axil_req_i.wdata;
                hold_q.wstrb    <= axil_req_i.wstrb;
                hold_q.err      <= out_of_range(axil_req_i.awaddr);
            end else if (rd_take) begin
                hold_q.valid    <= 1'b1;
                hold_q.is_write <= 1'b0;
                hold_q.base     <= word_base(axil_req_i.araddr);
                hold_q.wdata    <= '0;                  // Unused on reads
                hold_q.wstrb    <= '0;
                hold_q.err      <= out_of_range(axil_req_i.araddr);
            end else if (cmd_ready_i) begin
                hold_q.valid <= 1'b0;                   // Sequencer took it
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/pet_mem_pkg.sv
/* Shared widths and bus types of the AXI4-Lite to byte SRAM bridge.
   Only aligned 32-bit words and 128 KiB of SRAM behind one port. */
`default_nettype none

package pet_mem_pkg;

    // ------------------------------------------------------------
    // Widths
    localparam int RAM_ADDR_WIDTH = 17;                 // 128 KiB of SRAM
    localparam int DATA_WIDTH     = 8;                  // SRAM byte
    localparam int AXI_ADDR_WIDTH = 32;
    localparam int AXI_DATA_WIDTH = 32;
    localparam int LANES          = 4;                  // Bytes per AXI word

    typedef logic [RAM_ADDR_WIDTH-1:0] ram_addr_t;
    typedef logic [DATA_WIDTH-1:0]     ram_byte_t;
    typedef logic [AXI_ADDR_WIDTH-1:0] axi_addr_t;
    typedef logic [AXI_DATA_WIDTH-1:0] axi_word_t;
    typedef logic [LANES-1:0]          axi_strb_t;
    typedef logic [1:0]                axi_resp_t;

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    // ------------------------------------------------------------
    // AXI4-Lite channels of the host and the bridge
    typedef struct packed {
        logic      awvalid;
        axi_addr_t awaddr;
        logic      wvalid;
        axi_word_t wdata;
        axi_strb_t wstrb;
        logic      bready;
        logic      arvalid;
        axi_addr_t araddr;
        logic      rready;
    } axil_req_t;

    typedef struct packed {
        logic      awready;
        logic      wready;
        logic      arready;
        logic      bvalid;
        axi_resp_t bresp;
        logic      rvalid;
        axi_word_t rdata;
        axi_resp_t rresp;
    } axil_rsp_t;

    // ------------------------------------------------------------
    // Internal request and result
    typedef struct packed {
        logic      valid;
        logic      is_write;
        ram_addr_t base;                                // Low two bits zero
        axi_word_t wdata;
        axi_strb_t wstrb;
        logic      err;                                 // Address beyond the SRAM
    } mem_cmd_t;

    typedef struct packed {
        logic      valid;
        logic      is_write;
        axi_word_t rdata;
        axi_resp_t resp;
    } mem_rsp_t;

    typedef enum logic [2:0] {
        IDLE,
        WRITE_LANES,
        READ_LANES,
        READ_DRAIN,
        DONE
    } seq_state_t;

endpackage

`default_nettype wire
